// ==== list.f ====
hw/cc_pkg.sv
hw/warp_table.sv
hw/warp_scheduler.sv
hw/warp_exec.sv
hw/tblock_done_fifo.sv
hw/compute_cluster.sv
tests/tb_clock.sv
tests/tb_compute_cluster.sv

// ==== Makefile ====
TOP  = tb_compute_cluster
SRCS = $(wildcard hw/*.sv tests/*.sv)

all: run

obj_dir/V$(TOP): list.f $(SRCS)
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// ==== tests/tb_compute_cluster.sv ====
/* Compute cluster testbench
   Directed tests with an instruction memory model, a store log
   and a completion log */
module tb_compute_cluster import cc_pkg::*; ();

    localparam int Timeout    = 2000;
    localparam int HoldCycles = 8;
    localparam int ProgA      = 16;
    localparam int ProgB      = 32;
    localparam int ProgC      = 48;

    logic        clk;
    logic        rst;
    logic        allocate_warp;
    alloc_req_t  allocate_req;
    logic        done_ready;
    logic        imem_rsp_valid = 1'b0;
    inst_t       imem_rsp_data  = '0;
    logic        warp_free;
    logic        done_valid;
    tgroup_id_t  done_id;
    logic        imem_req;
    pc_t         imem_addr;
    logic        mem_we;
    addr_t       mem_addr;
    word_t       mem_wdata;

    inst_t       imem [256];
    pc_t         fetch_log [$];
    addr_t       wr_addr_log [$];
    word_t       wr_data_log [$];
    tgroup_id_t  done_log [$];
    tgroup_id_t  started_ids [$];
    logic [31:0] lat_rng = 32'd83;
    logic [31:0] blk_rng = 32'd83;
    int unsigned rsp_wait;
    pc_t         rsp_addr;
    int          checks;
    int          errors;

    tb_clock clock0 (
        .clk_o( clk ),
        .rst_o( rst )
    );

    compute_cluster #(
        .NumWarps( 4 )
    ) dut0 (
        .clk_i              ( clk            ),
        .rst_i              ( rst            ),
        .warp_free_o        ( warp_free      ),
        .allocate_warp_i    ( allocate_warp  ),
        .allocate_req_i     ( allocate_req   ),
        .tblock_done_ready_i( done_ready     ),
        .tblock_done_o      ( done_valid     ),
        .tblock_done_id_o   ( done_id        ),
        .imem_req_o         ( imem_req       ),
        .imem_addr_o        ( imem_addr      ),
        .imem_rsp_valid_i   ( imem_rsp_valid ),
        .imem_rsp_data_i    ( imem_rsp_data  ),
        .mem_we_o           ( mem_we         ),
        .mem_addr_o         ( mem_addr       ),
        .mem_wdata_o        ( mem_wdata      )
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Opcode in 31:28, immediate in 23:0
    function automatic inst_t encode(input opcode_e op, input imm_t imm);
        return {4'(op), 4'h0, imm};
    endfunction

    function automatic alloc_req_t make_req(input pc_t pc, input addr_t dp,
                                            input tblock_idx_t idx, input tgroup_id_t grp);
        alloc_req_t r;
        r.pc         = pc;
        r.dp_addr    = dp;
        r.tblock_idx = idx;
        r.tgroup_id  = grp;
        return r;
    endfunction

    // Group ID shifted up one byte above the block index
    function automatic word_t store_word(input alloc_req_t r);
        return (word_t'(r.tgroup_id) << 8) | word_t'(r.tblock_idx);
    endfunction

    function automatic logic in_program_range(input pc_t pc);
        int p;
        p = int'(pc);
        return (p >= ProgA && p <= ProgA + 2) || (p >= ProgB && p <= ProgB + 2)
            || p == ProgC;
    endfunction

    // Instruction memory, answers 1 to 3 cycles after each request
    always @(posedge clk) begin : imem_model
        imem_rsp_valid <= 1'b0;
        if (rst) begin
            rsp_wait = 0;
        end else begin
            if (imem_req) begin
                fetch_log.push_back(imem_addr);
                rsp_addr = imem_addr;
                lat_rng  = xorshift(lat_rng);
                rsp_wait = 1 + lat_rng % 3;
            end
            if (rsp_wait != 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    imem_rsp_valid <= 1'b1;
                    imem_rsp_data  <= imem[rsp_addr[7:0]];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && mem_we) begin
            wr_addr_log.push_back(mem_addr);
            wr_data_log.push_back(mem_wdata);
        end
        if (!rst && done_valid && done_ready) begin
            done_log.push_back(done_id);
        end
    end

    task automatic note_failure(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input tgroup_id_t expected,
                            input tgroup_id_t actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        $display("test %s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic clear_logs();
        fetch_log.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        done_log.delete();
        started_ids.delete();
    endtask

    task automatic load_programs();
        // Unused words decode as EXIT so a stray warp ends
        for (int i = 0; i < 256; i++) begin
            imem[i] = {4'(OP_EXIT), 4'h0, 16'h0000, 8'(i)};
        end
        imem[ProgA]     = encode(OP_NOP, 24'd0);
        imem[ProgA + 1] = encode(OP_STORE, 24'd4);
        imem[ProgA + 2] = encode(OP_EXIT, 24'd0);
        imem[ProgB]     = encode(OP_STORE, 24'd0);
        imem[ProgB + 1] = encode(OP_STORE, 24'd8);
        imem[ProgB + 2] = encode(OP_EXIT, 24'd0);
        imem[ProgC]     = encode(OP_EXIT, 24'd0);
    endtask

    // Holds the request until an edge where a free slot takes it
    task automatic start_block(input alloc_req_t req);
        int n;
        n = 0;
        @(posedge clk);
        allocate_warp <= 1'b1;
        allocate_req  <= req;
        @(posedge clk);
        while (!warp_free && n < Timeout) begin
            @(posedge clk);
            n++;
        end
        allocate_warp <= 1'b0;
        if (n >= Timeout) begin
            note_failure($sformatf("block of group %h was never accepted", req.tgroup_id));
        end
    endtask

    task automatic wait_done_count(input int count);
        int n;
        n = 0;
        while (done_log.size() < count && n < Timeout) begin
            @(posedge clk);
            n++;
        end
        if (done_log.size() < count) begin
            note_failure($sformatf("timed out waiting for %0d completed blocks, saw %0d",
                                   count, done_log.size()));
        end
    endtask

    task automatic wait_fetch_count(input int count);
        int n;
        n = 0;
        while (fetch_log.size() < count && n < Timeout) begin
            @(posedge clk);
            n++;
        end
        if (fetch_log.size() < count) begin
            note_failure($sformatf("timed out waiting for %0d fetches", count));
        end
    endtask

    task automatic wait_done_valid();
        int n;
        n = 0;
        @(posedge clk);
        while (!done_valid && n < Timeout) begin
            @(posedge clk);
            n++;
        end
        if (!done_valid) begin
            note_failure("timed out waiting for tblock_done_o");
        end
    endtask

    // Every started group ID must come back as often as it was started
    task automatic compare_done_ids();
        int exp_n;
        int got_n;
        if (done_log.size() != started_ids.size()) begin
            note_failure($sformatf("%0d blocks completed but %0d were started",
                                   done_log.size(), started_ids.size()));
        end
        foreach (started_ids[i]) begin
            exp_n = 0;
            got_n = 0;
            foreach (started_ids[j]) begin
                if (started_ids[j] == started_ids[i]) begin
                    exp_n++;
                end
            end
            foreach (done_log[j]) begin
                if (done_log[j] == started_ids[i]) begin
                    got_n++;
                end
            end
            if (exp_n != got_n) begin
                note_failure($sformatf("group ID %h completed %0d times, expected %0d",
                                       started_ids[i], got_n, exp_n));
            end
        end
    endtask

    task automatic reset_values();
        int errs;
        errs = errors;
        check_bit("imem_req_o", 1'b0, imem_req);
        check_bit("mem_we_o", 1'b0, mem_we);
        check_bit("tblock_done_o", 1'b0, done_valid);
        check_bit("warp_free_o", 1'b1, warp_free);
        finish_test("reset", errs);
    endtask

    task automatic single_block();
        int         errs;
        alloc_req_t req;
        errs = errors;
        clear_logs();
        req = make_req(pc_t'(ProgA), 24'h001000, 8'h05, 8'h21);
        start_block(req);
        wait_done_count(1);
        if (fetch_log.size() != 3) begin
            note_failure($sformatf("expected 3 fetches, saw %0d", fetch_log.size()));
        end else begin
            for (int i = 0; i < 3; i++) begin
                check_pc($sformatf("imem_addr_o[%0d]", i), pc_t'(ProgA + i), fetch_log[i]);
            end
        end
        if (wr_addr_log.size() != 1) begin
            note_failure($sformatf("expected 1 write, saw %0d", wr_addr_log.size()));
        end else begin
            check_addr("mem_addr_o", req.dp_addr + 24'd4, wr_addr_log[0]);
            check_word("mem_wdata_o", store_word(req), wr_data_log[0]);
        end
        if (done_log.size() == 1) begin
            check_id("tblock_done_id_o", req.tgroup_id, done_log[0]);
        end
        finish_test("single block", errs);
    endtask

    task automatic full_table();
        int         errs;
        alloc_req_t req;
        errs = errors;
        clear_logs();
        for (int i = 0; i < 4; i++) begin
            req = make_req(pc_t'(ProgB), 24'h020000 + addr_t'(i * 256), 8'(i), 8'h30 + 8'(i));
            started_ids.push_back(req.tgroup_id);
            start_block(req);
        end
        @(posedge clk);
        check_bit("warp_free_o", 1'b0, warp_free);
        wait_done_count(4);
        @(posedge clk);
        check_bit("warp_free_o", 1'b1, warp_free);
        compare_done_ids();
        finish_test("full table", errs);
    endtask

    task automatic done_backpressure();
        int         errs;
        tgroup_id_t held_id;
        errs = errors;
        clear_logs();
        @(posedge clk);
        done_ready <= 1'b0;
        for (int i = 0; i < 2; i++) begin
            started_ids.push_back(8'h41 + 8'(i));
            start_block(make_req(pc_t'(ProgA), 24'h030000, 8'(i), 8'h41 + 8'(i)));
        end
        wait_fetch_count(6);
        wait_done_valid();
        // The first block stays one instruction ahead under round robin and exits first
        held_id = 8'h41;
        check_id("tblock_done_id_o", held_id, done_id);
        // Second exit lands inside this window
        for (int i = 0; i < HoldCycles; i++) begin
            @(posedge clk);
            check_bit("tblock_done_o", 1'b1, done_valid);
            check_id("tblock_done_id_o", held_id, done_id);
        end
        started_ids.push_back(8'h43);
        start_block(make_req(pc_t'(ProgA), 24'h031000, 8'h02, 8'h43));
        check_bit("tblock_done_o", 1'b1, done_valid);
        check_id("tblock_done_id_o", held_id, done_id);
        @(posedge clk);
        done_ready <= 1'b1;
        wait_done_count(3);
        if (done_log.size() > 0) begin
            check_id("first drained ID", held_id, done_log[0]);
        end
        compare_done_ids();
        finish_test("completion back-pressure", errs);
    endtask

    task automatic random_blocks();
        int          errs;
        int          found;
        alloc_req_t  req;
        logic [31:0] sel;
        addr_t       exp_addr [$];
        word_t       exp_word [$];
        errs = errors;
        clear_logs();
        for (int i = 0; i < 12; i++) begin
            blk_rng        = xorshift(blk_rng);
            req.dp_addr    = blk_rng[23:0];
            blk_rng        = xorshift(blk_rng);
            req.tblock_idx = blk_rng[7:0];
            req.tgroup_id  = blk_rng[15:8];
            sel            = blk_rng[31:16] % 3;
            case (sel)
                0: begin
                    req.pc = pc_t'(ProgA);
                    exp_addr.push_back(req.dp_addr + 24'd4);
                    exp_word.push_back(store_word(req));
                end
                1: begin
                    req.pc = pc_t'(ProgB);
                    exp_addr.push_back(req.dp_addr);
                    exp_word.push_back(store_word(req));
                    exp_addr.push_back(req.dp_addr + 24'd8);
                    exp_word.push_back(store_word(req));
                end
                default: req.pc = pc_t'(ProgC);
            endcase
            started_ids.push_back(req.tgroup_id);
            start_block(req);
        end
        wait_done_count(12);
        if (wr_addr_log.size() != exp_addr.size()) begin
            note_failure($sformatf("saw %0d writes, expected %0d",
                                   wr_addr_log.size(), exp_addr.size()));
        end
        foreach (wr_addr_log[i]) begin
            found = -1;
            foreach (exp_addr[j]) begin
                if (found < 0 && exp_addr[j] == wr_addr_log[i]) begin
                    found = j;
                end
            end
            if (found < 0) begin
                note_failure($sformatf("unexpected write to address %h", wr_addr_log[i]));
            end else begin
                check_word("mem_wdata_o", exp_word[found], wr_data_log[i]);
                exp_addr.delete(found);
                exp_word.delete(found);
            end
        end
        foreach (fetch_log[i]) begin
            if (!in_program_range(fetch_log[i])) begin
                note_failure($sformatf("fetch from %h is outside every program", fetch_log[i]));
            end
        end
        compare_done_ids();
        finish_test("random blocks", errs);
    endtask

    initial begin : main
        int n;
        checks        = 0;
        errors        = 0;
        allocate_warp = 1'b0;
        allocate_req  = '0;
        done_ready    = 1'b1;
        load_programs();
        n = 0;
        @(posedge clk);
        while (rst && n < Timeout) begin
            @(posedge clk);
            n++;
        end
        if (rst) begin
            note_failure("reset never released");
        end
        reset_values();
        single_block();
        full_table();
        done_backpressure();
        random_blocks();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
/* Testbench clock and reset
   100 unit clock period, reset held high for the first 5 rising edges */
module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        rst_o <= 1'b0;
    end

    always #50 clk_o = ~clk_o;

endmodule

// ==== hw/compute_cluster.sv ====
/* Compute cluster top level
   Warp table, scheduler, execute stage and completion queue */
module compute_cluster import cc_pkg::*; #(
    parameter int unsigned NumWarps = 4
) (
    input  logic       clk_i,
    input  logic       rst_i,

    output logic       warp_free_o,
    input  logic       allocate_warp_i,
    input  alloc_req_t allocate_req_i,

    input  logic       tblock_done_ready_i,
    output logic       tblock_done_o,
    output tgroup_id_t tblock_done_id_o,

    output logic       imem_req_o,
    output pc_t        imem_addr_o,
    input  logic       imem_rsp_valid_i,
    input  inst_t      imem_rsp_data_i,

    output logic       mem_we_o,
    output addr_t      mem_addr_o,
    output word_t      mem_wdata_o
);

    localparam int unsigned WarpIdxW = NumWarps > 1 ? $clog2(NumWarps) : 1;

    logic [NumWarps-1:0] active;
    alloc_req_t          slots [NumWarps];
    pc_t                 slot_pc [NumWarps];
    alloc_req_t          exec_slot;
    logic                fetch_start;
    warp_id_t            fetch_warp;
    logic                update_valid;
    pc_update_t          update;
    logic                done_push;
    tgroup_id_t          done_id;

    for (genvar w = 0; w < NumWarps; w++) begin : gen_slot_pc
        assign slot_pc[w] = slots[w].pc;
    end

    // Context of the warp being served, held by the scheduler until its update
    assign exec_slot = slots[fetch_warp[WarpIdxW-1:0]];

    warp_table #(
        .NumWarps( NumWarps )
    ) i_warp_table (
        .clk_i          ( clk_i           ),
        .rst_i          ( rst_i           ),
        .allocate_warp_i( allocate_warp_i ),
        .allocate_req_i ( allocate_req_i  ),
        .warp_free_o    ( warp_free_o     ),
        .active_o       ( active          ),
        .fetch_start_i  ( fetch_start     ),
        .fetch_warp_i   ( fetch_warp      ),
        .slot_o         ( slots           ),
        .update_valid_i ( update_valid    ),
        .update_i       ( update          )
    );

    warp_scheduler #(
        .NumWarps( NumWarps )
    ) i_warp_scheduler (
        .clk_i           ( clk_i            ),
        .rst_i           ( rst_i            ),
        .active_i        ( active           ),
        .slot_pc_i       ( slot_pc          ),
        .imem_req_o      ( imem_req_o       ),
        .imem_addr_o     ( imem_addr_o      ),
        .imem_rsp_valid_i( imem_rsp_valid_i ),
        .update_valid_i  ( update_valid     ),
        .fetch_start_o   ( fetch_start      ),
        .fetch_warp_o    ( fetch_warp       )
    );

    warp_exec i_warp_exec (
        .clk_i           ( clk_i            ),
        .rst_i           ( rst_i            ),
        .imem_rsp_valid_i( imem_rsp_valid_i ),
        .imem_rsp_data_i ( imem_rsp_data_i  ),
        .warp_i          ( fetch_warp       ),
        .slot_i          ( exec_slot        ),
        .update_valid_o  ( update_valid     ),
        .update_o        ( update           ),
        .mem_we_o        ( mem_we_o         ),
        .mem_addr_o      ( mem_addr_o       ),
        .mem_wdata_o     ( mem_wdata_o      ),
        .done_push_o     ( done_push        ),
        .done_id_o       ( done_id          )
    );

    tblock_done_fifo #(
        .NumWarps( NumWarps )
    ) i_tblock_done_fifo (
        .clk_i              ( clk_i               ),
        .rst_i              ( rst_i               ),
        .push_i             ( done_push           ),
        .push_id_i          ( done_id             ),
        .tblock_done_o      ( tblock_done_o       ),
        .tblock_done_id_o   ( tblock_done_id_o    ),
        .tblock_done_ready_i( tblock_done_ready_i )
    );

endmodule

// ==== hw/tblock_done_fifo.sv ====
/* Completion queue
   Circular buffer of finished group IDs behind a valid/ready port */
module tblock_done_fifo import cc_pkg::*; #(
    parameter int unsigned NumWarps = 4
) (
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       push_i,
    input  tgroup_id_t push_id_i,

    output logic       tblock_done_o,
    output tgroup_id_t tblock_done_id_o,
    input  logic       tblock_done_ready_i
);

    localparam int unsigned PtrW = NumWarps > 1 ? $clog2(NumWarps) : 1;
    localparam int unsigned CntW = $clog2(NumWarps + 1);

    tgroup_id_t      mem_q [NumWarps];
    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] wr_ptr_q;
    logic [CntW-1:0] count_q;
    logic            pop;

    function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(NumWarps - 1)) begin
            return '0;
        end
        return ptr + PtrW'(1);
    endfunction

    assign tblock_done_o    = count_q != '0;
    assign tblock_done_id_o = mem_q[rd_ptr_q];
    assign pop              = tblock_done_o && tblock_done_ready_i;

    // Depth matches the warp count, so a push never finds the queue full
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + CntW'(1);
                2'b01:   count_q <= count_q - CntW'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_id_i;
        end
    end

endmodule

// ==== hw/warp_exec.sv ====
/* Warp execute stage
   Registers a fetched instruction, decodes it and issues the PC update,
   the data store and the block exit */
module warp_exec import cc_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       imem_rsp_valid_i,
    input  inst_t      imem_rsp_data_i,
    input  warp_id_t   warp_i,
    input  alloc_req_t slot_i,

    output logic       update_valid_o,
    output pc_update_t update_o,

    output logic       mem_we_o,
    output addr_t      mem_addr_o,
    output word_t      mem_wdata_o,

    output logic       done_push_o,
    output tgroup_id_t done_id_o
);

    logic     valid_q;
    inst_t    inst_q;
    warp_id_t warp_q;
    opcode_e  opcode;
    imm_t     imm;
    logic     is_store;
    logic     is_exit;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= imem_rsp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (imem_rsp_valid_i) begin
            inst_q <= imem_rsp_data_i;
            warp_q <= warp_i;
        end
    end

    assign opcode = opcode_e'(inst_q[31:28]);
    assign imm    = inst_q[23:0];

    always_comb begin
        is_store = 1'b0;
        is_exit  = 1'b0;
        case (opcode)
            OP_STORE: is_store = 1'b1;
            OP_EXIT:  is_exit  = 1'b1;
            // OP_NOP and unknown codes only step the PC
            default: ;
        endcase
    end

    assign update_valid_o     = valid_q;
    assign update_o.warp_id   = warp_q;
    assign update_o.next_pc   = slot_i.pc + pc_t'(1);
    assign update_o.exit_flag = is_exit;

    assign mem_we_o    = valid_q && is_store;
    assign mem_addr_o  = slot_i.dp_addr + imm;
    // Group ID in 15:8, block index in 7:0
    assign mem_wdata_o = {16'h0000, slot_i.tgroup_id, slot_i.tblock_idx};

    assign done_push_o = valid_q && is_exit;
    assign done_id_o   = slot_i.tgroup_id;

endmodule

// ==== hw/warp_scheduler.sv ====
/* Warp scheduler
   Round-robin selection of ready warps, one instruction fetch in flight */
module warp_scheduler import cc_pkg::*; #(
    parameter int unsigned NumWarps = 4
) (
    input  logic                clk_i,
    input  logic                rst_i,

    input  logic [NumWarps-1:0] active_i,
    input  pc_t                 slot_pc_i [NumWarps],

    output logic                imem_req_o,
    output pc_t                 imem_addr_o,
    input  logic                imem_rsp_valid_i,

    input  logic                update_valid_i,

    output logic                fetch_start_o,
    output warp_id_t            fetch_warp_o
);

    localparam int unsigned WarpIdxW = NumWarps > 1 ? $clog2(NumWarps) : 1;

    sched_state_e        state_q;
    sched_state_e        state_d;
    logic [WarpIdxW-1:0] last_q;
    logic [WarpIdxW-1:0] pick;
    logic [WarpIdxW-1:0] cand;
    logic                found;
    logic                rsp_pending_q;

    // Search starts right after the last served warp
    always_comb begin
        pick  = last_q;
        found = 1'b0;
        cand  = '0;
        for (int unsigned i = 1; i <= NumWarps; i++) begin
            cand = WarpIdxW'((last_q + i) % NumWarps);
            if (!found && active_i[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign fetch_start_o = (state_q == ST_IDLE) && found;
    assign imem_req_o    = fetch_start_o;
    assign imem_addr_o   = slot_pc_i[pick];
    // last_q doubles as the warp currently being served
    assign fetch_warp_o  = warp_id_t'((state_q == ST_IDLE) ? pick : last_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (fetch_start_o) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                // Back to idle once the fetched instruction has executed
                if (update_valid_i && !rsp_pending_q) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q       <= ST_IDLE;
            last_q        <= WarpIdxW'(NumWarps - 1);
            rsp_pending_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (fetch_start_o) begin
                last_q        <= pick;
                rsp_pending_q <= 1'b1;
            end else if (imem_rsp_valid_i) begin
                rsp_pending_q <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/warp_table.sv ====
/* Warp table
   Holds one thread block context per warp slot, allocates free slots
   and applies PC updates and exits */
module warp_table import cc_pkg::*; #(
    parameter int unsigned NumWarps = 4
) (
    input  logic                clk_i,
    input  logic                rst_i,

    input  logic                allocate_warp_i,
    input  alloc_req_t          allocate_req_i,
    output logic                warp_free_o,

    output logic [NumWarps-1:0] active_o,

    input  logic                fetch_start_i,
    input  warp_id_t            fetch_warp_i,
    output alloc_req_t          slot_o [NumWarps],

    input  logic                update_valid_i,
    input  pc_update_t          update_i
);

    localparam int unsigned WarpIdxW = NumWarps > 1 ? $clog2(NumWarps) : 1;

    logic [NumWarps-1:0] active_q;
    logic [NumWarps-1:0] busy_q;
    alloc_req_t          slot_q [NumWarps];
    logic [WarpIdxW-1:0] free_idx;
    logic [WarpIdxW-1:0] fetch_idx;
    logic [WarpIdxW-1:0] update_idx;
    logic                alloc_accept;

    assign fetch_idx    = fetch_warp_i[WarpIdxW-1:0];
    assign update_idx   = update_i.warp_id[WarpIdxW-1:0];
    assign warp_free_o  = ~&active_q;
    assign alloc_accept = allocate_warp_i && warp_free_o;

    // Lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int i = NumWarps - 1; i >= 0; i--) begin
            if (!active_q[i]) begin
                free_idx = WarpIdxW'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            active_q <= '0;
            busy_q   <= '0;
        end else begin
            if (alloc_accept) begin
                active_q[free_idx] <= 1'b1;
                busy_q[free_idx]   <= 1'b0;
            end
            if (fetch_start_i) begin
                busy_q[fetch_idx] <= 1'b1;
            end
            if (update_valid_i) begin
                busy_q[update_idx] <= 1'b0;
                if (update_i.exit_flag) begin
                    active_q[update_idx] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_accept) begin
            slot_q[free_idx] <= allocate_req_i;
        end
        if (update_valid_i && !update_i.exit_flag) begin
            slot_q[update_idx].pc <= update_i.next_pc;
        end
    end

    // Only warps without a fetch in flight are offered to the scheduler
    assign active_o = active_q & ~busy_q;
    assign slot_o   = slot_q;

endmodule

// ==== hw/cc_pkg.sv ====
/* Compute cluster shared types
   Widths, instruction format, opcodes and the warp slot context */
package cc_pkg;

    // Upper bound for warp IDs carried between blocks
    localparam int unsigned WarpIdBits = 4;

    typedef logic [15:0]           pc_t;
    typedef logic [23:0]           addr_t;
    typedef logic [7:0]            tblock_idx_t;
    typedef logic [7:0]            tgroup_id_t;
    typedef logic [31:0]           word_t;
    typedef logic [23:0]           imm_t;
    typedef logic [WarpIdBits-1:0] warp_id_t;

    // Opcode in bits 31:28, immediate offset in bits 23:0
    typedef logic [31:0] inst_t;

    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_STORE = 4'h1,
        OP_EXIT  = 4'h2
    } opcode_e;

    // Allocation request, also the context held per warp slot
    typedef struct packed {
        pc_t         pc;
        addr_t       dp_addr;
        tblock_idx_t tblock_idx;
        tgroup_id_t  tgroup_id;
    } alloc_req_t;

    typedef struct packed {
        warp_id_t warp_id;
        pc_t      next_pc;
        logic     exit_flag;
    } pc_update_t;

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } sched_state_e;

endpackage
